// ==== design/core_pkg.sv ====
/*
 * core package
 * shared word, strobe and operation types plus the memory stage payloads
 */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        NULL,
        ALU,
        LOAD_WORD,
        LOAD_HALF,
        LOAD_BYTE,
        LOAD_HALF_UNSIGNED,
        LOAD_BYTE_UNSIGNED,
        STORE_WORD,
        STORE_HALF,
        STORE_BYTE
    } op_t;

    // item entering the memory stage
    typedef struct packed {
        op_t       op;
        word_t     alu;
        word_t     rs2;
        reg_addr_t rd;
    } mm_t;

    // item leaving towards writeback
    typedef struct packed {
        op_t       op;
        reg_addr_t rd;
        word_t     rd_data;
    } wb_t;

    function automatic logic is_load(op_t op);
        case (op)
            LOAD_WORD, LOAD_HALF, LOAD_BYTE,
            LOAD_HALF_UNSIGNED, LOAD_BYTE_UNSIGNED: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_store(op_t op);
        case (op)
            STORE_WORD, STORE_HALF, STORE_BYTE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

// ==== design/stream_if.sv ====
/*
 * stream interface
 * valid/ready handshake carrying one payload of any type per transfer
 */
interface stream_if #(
    parameter type payload_t = logic [31:0]
) ();

    logic     valid;
    logic     ready;
    payload_t data;

    // source holds valid and data until ready is seen
    modport source (output valid, output data, input ready);
    modport sink (input valid, input data, output ready);

endinterface

// ==== design/wb_if.sv ====
/*
 * wishbone classic bus
 * single access, ack closes each cycle
 */
interface wb_if ();

    logic               cyc;
    logic               stb;
    logic               we;
    core_pkg::word_t    adr;
    core_pkg::strb_t    sel;
    core_pkg::word_t    dat_w;
    core_pkg::word_t    dat_r;
    logic               ack;

    modport master (
        output cyc, stb, we, adr, sel, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, sel, dat_w,
        output dat_r, ack
    );

endinterface

// ==== design/mem_align.sv ====
/*
 * memory alignment
 * places store data on its byte lanes with selects, and pulls load data
 * out of the bus word with sign or zero extension
 */
module mem_align (
    input  core_pkg::op_t   op,
    input  logic [1:0]      offset,
    input  core_pkg::word_t store_in,
    output core_pkg::word_t store_out,
    output core_pkg::strb_t sel,
    input  core_pkg::word_t load_in,
    output core_pkg::word_t load_out
);

    logic [15:0] lane_half;
    logic [7:0]  lane_byte;

    // store side
    always_comb begin
        sel       = '0;
        store_out = store_in;
        case (op)
            core_pkg::STORE_WORD: begin
                sel = 4'b1111;
            end
            core_pkg::STORE_HALF: begin
                sel       = offset[1] ? 4'b1100 : 4'b0011;
                store_out = offset[1] ? {store_in[15:0], 16'h0000} : store_in;
            end
            core_pkg::STORE_BYTE: begin
                sel       = 4'b0001 << offset;
                store_out = store_in << {offset, 3'b000};
            end
            default: begin
                sel = '0;
            end
        endcase
    end

    // load side, half and byte picked by the low address bits
    assign lane_half = offset[1] ? load_in[31:16] : load_in[15:0];
    assign lane_byte = load_in[{offset, 3'b000} +: 8];

    always_comb begin
        case (op)
            core_pkg::LOAD_HALF:
                load_out = {{16{lane_half[15]}}, lane_half};
            core_pkg::LOAD_HALF_UNSIGNED:
                load_out = {16'h0000, lane_half};
            core_pkg::LOAD_BYTE:
                load_out = {{24{lane_byte[7]}}, lane_byte};
            core_pkg::LOAD_BYTE_UNSIGNED:
                load_out = {24'h000000, lane_byte};
            default:
                load_out = load_in;
        endcase
    end

endmodule

// ==== design/mem_control.sv ====
/*
 * memory controller
 * takes one stage item at a time, runs a wishbone cycle for loads and
 * stores, and hands one writeback item downstream per instruction
 */
module mem_control #(
    parameter core_pkg::word_t BASE = '0,
    parameter int unsigned     SIZE = 4096
) (
    input  logic     cache,
    input  logic     rstart,
    stream_if.sink   up,
    stream_if.source down,
    wb_if.master     bus
);

    typedef enum logic [1:0] {IDLE, BUS, OUT} state_t;

    state_t          state;
    core_pkg::mm_t   item;
    core_pkg::wb_t   out_q;
    logic            out_valid;
    logic            accept;
    logic            up_mem;
    logic            misaligned;
    core_pkg::word_t offset_addr;
    core_pkg::word_t load_data;

    assign up_mem = core_pkg::is_load(up.data.op) || core_pkg::is_store(up.data.op);

    // only take an item when idle and the output slot is free or draining
    assign up.ready = up.valid && state == IDLE && (!out_valid || down.ready);
    assign accept   = up.valid && up.ready;

    always_ff @(posedge cache) begin
        if (rstart) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (accept && up_mem) state <= BUS;
                BUS:  if (bus.ack) state <= OUT;
                OUT:  if (down.ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge cache) begin
        if (accept && up_mem) begin
            item <= up.data;
        end
    end

    // the bus address is the word index inside the window
    assign offset_addr = item.alu - BASE;
    assign bus.cyc     = state == BUS;
    assign bus.stb     = state == BUS;
    assign bus.we      = core_pkg::is_store(item.op);
    assign bus.adr     = (offset_addr & core_pkg::word_t'(SIZE - 1)) >> 2;

    mem_align align0 (
        .op        (item.op),
        .offset    (item.alu[1:0]),
        .store_in  (item.rs2),
        .store_out (bus.dat_w),
        .sel       (bus.sel),
        .load_in   (bus.dat_r),
        .load_out  (load_data)
    );

    // the output register fills straight from up or at the end of a bus cycle
    always_ff @(posedge cache) begin
        if (accept && !up_mem) begin
            out_q.op      <= up.data.op;
            out_q.rd      <= up.data.rd;
            out_q.rd_data <= up.data.alu;
        end else if (state == BUS && bus.ack) begin
            out_q.op      <= item.op;
            out_q.rd      <= item.rd;
            out_q.rd_data <= core_pkg::is_load(item.op) ? load_data : item.alu;
        end
    end

    always_ff @(posedge cache) begin
        if (rstart) begin
            out_valid <= 1'b0;
        end else if ((accept && !up_mem) || (state == BUS && bus.ack)) begin
            out_valid <= 1'b1;
        end else if (down.ready) begin
            out_valid <= 1'b0;
        end
    end

    assign down.valid = out_valid;
    assign down.data  = out_q;

    always_comb begin
        case (up.data.op)
            core_pkg::LOAD_WORD, core_pkg::STORE_WORD:
                misaligned = up.data.alu[1:0] != 2'b00;
            core_pkg::LOAD_HALF, core_pkg::LOAD_HALF_UNSIGNED, core_pkg::STORE_HALF:
                misaligned = up.data.alu[0];
            default:
                misaligned = 1'b0;
        endcase
    end

    a_window: assert property (@(posedge cache) disable iff (rstart)
        accept && up_mem |-> core_pkg::word_t'(up.data.alu - BASE) < SIZE);

    a_aligned: assert property (@(posedge cache) disable iff (rstart)
        accept && up_mem |-> !misaligned);

    // the master holds its request until the slave answers
    a_hold_until_ack: assert property (@(posedge cache) disable iff (rstart)
        bus.cyc && !bus.ack |=> bus.cyc && bus.stb && $stable(bus.we) && $stable(bus.adr)
            && $stable(bus.sel) && $stable(bus.dat_w));

    // one item in flight so the output slot stays empty during a bus cycle
    a_slot_empty_on_bus: assert property (@(posedge cache) disable iff (rstart)
        bus.cyc |-> !down.valid);

endmodule

// ==== design/data_ram.sv ====
/*
 * data memory
 * wishbone slave word RAM with byte select writes and a fixed wait count
 */
module data_ram #(
    parameter int unsigned SIZE        = 4096,
    parameter int unsigned WAIT_STATES = 1
) (
    input  logic cache,
    input  logic rstart,
    wb_if.slave  bus
);

    localparam int unsigned DEPTH = SIZE / 4;
    localparam int unsigned IW    = $clog2(DEPTH);
    localparam int unsigned CW    = $clog2(WAIT_STATES + 2);

    core_pkg::word_t mem [DEPTH];
    logic [CW-1:0]   count;
    logic [IW-1:0]   idx;

    assign idx = bus.adr[IW-1:0];

    // ack once the open cycle has waited long enough
    assign bus.ack   = bus.cyc && bus.stb && count == CW'(WAIT_STATES);
    assign bus.dat_r = mem[idx];

    always_ff @(posedge cache) begin
        if (rstart) begin
            count <= '0;
        end else if (bus.ack) begin
            count <= '0;
        end else if (bus.cyc && bus.stb) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge cache) begin
        if (bus.ack && bus.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.sel[i]) begin
                    mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
                end
            end
        end
    end

    // ack comes after the set number of wait cycles and lasts one cycle
    a_ack_timing: assert property (@(posedge cache) disable iff (rstart)
        $rose(bus.stb) |-> ##WAIT_STATES (bus.ack ##1 !bus.ack));

endmodule

// ==== design/mem_stage.sv ====
/*
 * memory stage top
 * bundles the plain stage ports into streams and joins controller and RAM
 */
module mem_stage #(
    parameter core_pkg::word_t BASE        = '0,
    parameter int unsigned     SIZE        = 4096,
    parameter int unsigned     WAIT_STATES = 1
) (
    input  logic                cache,
    input  logic                rstart,
    input  logic                up_valid,
    input  core_pkg::op_t       up_op,
    input  core_pkg::word_t     up_alu,
    input  core_pkg::word_t     up_rs2,
    input  core_pkg::reg_addr_t up_rd,
    output logic                up_ready,
    output logic                down_valid,
    input  logic                down_ready,
    output core_pkg::op_t       down_op,
    output core_pkg::reg_addr_t down_rd,
    output core_pkg::word_t     down_data
);

    stream_if #(.payload_t(core_pkg::mm_t)) up ();
    stream_if #(.payload_t(core_pkg::wb_t)) down ();
    wb_if bus ();

    assign up.valid    = up_valid;
    assign up.data.op  = up_op;
    assign up.data.alu = up_alu;
    assign up.data.rs2 = up_rs2;
    assign up.data.rd  = up_rd;
    assign up_ready    = up.ready;

    assign down.ready  = down_ready;
    assign down_valid  = down.valid;
    assign down_op     = down.data.op;
    assign down_rd     = down.data.rd;
    assign down_data   = down.data.rd_data;

    mem_control #(
        .BASE (BASE),
        .SIZE (SIZE)
    ) control0 (
        .cache  (cache),
        .rstart (rstart),
        .up     (up.sink),
        .down   (down.source),
        .bus    (bus.master)
    );

    data_ram #(
        .SIZE        (SIZE),
        .WAIT_STATES (WAIT_STATES)
    ) ram0 (
        .cache  (cache),
        .rstart (rstart),
        .bus    (bus.slave)
    );

endmodule

// ==== testbench/tb_mem_stage.sv ====
/*
 * memory stage testbench
 * random load/store/alu traffic checked against a byte image of the RAM
 */
module tb_mem_stage;

    localparam int WINDOW  = 4096;
    localparam int TIMEOUT = 200;

    logic                cache;
    logic                rstart;
    logic                up_valid;
    core_pkg::op_t       up_op;
    core_pkg::word_t     up_alu;
    core_pkg::word_t     up_rs2;
    core_pkg::reg_addr_t up_rd;
    logic                up_ready;
    logic                down_valid;
    logic                down_ready;
    core_pkg::op_t       down_op;
    core_pkg::reg_addr_t down_rd;
    core_pkg::word_t     down_data;

    logic [7:0]    mem_img [WINDOW];
    core_pkg::wb_t expected_q [$];
    logic [31:0]   lcg_state = 32'd62288;
    int            errors    = 0;
    int            ready_pct = 100;
    bit            timed_out = 1'b0;

    mem_stage dut0 (
        .cache      (cache),
        .rstart     (rstart),
        .up_valid   (up_valid),
        .up_op      (up_op),
        .up_alu     (up_alu),
        .up_rs2     (up_rs2),
        .up_rd      (up_rd),
        .up_ready   (up_ready),
        .down_valid (down_valid),
        .down_ready (down_ready),
        .down_op    (down_op),
        .down_rd    (down_rd),
        .down_data  (down_data)
    );

    initial begin
        cache = 1'b0;
        forever #2 cache = ~cache;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // bytes touched by a memory operation, zero for alu and null
    function automatic int access_bytes(core_pkg::op_t op);
        case (op)
            core_pkg::LOAD_WORD, core_pkg::STORE_WORD: return 4;
            core_pkg::LOAD_HALF, core_pkg::LOAD_HALF_UNSIGNED, core_pkg::STORE_HALF: return 2;
            core_pkg::LOAD_BYTE, core_pkg::LOAD_BYTE_UNSIGNED, core_pkg::STORE_BYTE: return 1;
            default: return 0;
        endcase
    endfunction

    // expected writeback for the item transferring now, stores update the image
    task automatic model_upstream();
        core_pkg::wb_t   exp;
        core_pkg::word_t v;
        int              a;
        int              n;
        a           = up_alu % WINDOW;
        n           = access_bytes(up_op);
        exp.op      = up_op;
        exp.rd      = up_rd;
        exp.rd_data = up_alu;
        case (up_op)
            core_pkg::LOAD_WORD, core_pkg::LOAD_HALF, core_pkg::LOAD_BYTE,
            core_pkg::LOAD_HALF_UNSIGNED, core_pkg::LOAD_BYTE_UNSIGNED: begin
                v = '0;
                for (int i = 0; i < n; i++) v[8*i +: 8] = mem_img[a + i];
                if ((up_op == core_pkg::LOAD_HALF || up_op == core_pkg::LOAD_BYTE)
                        && v[8*n-1]) begin
                    for (int i = 8 * n; i < 32; i++) v[i] = 1'b1;
                end
                exp.rd_data = v;
            end
            core_pkg::STORE_WORD, core_pkg::STORE_HALF, core_pkg::STORE_BYTE: begin
                for (int i = 0; i < n; i++) mem_img[a + i] = up_rs2[8*i +: 8];
            end
            default: ;
        endcase
        expected_q.push_back(exp);
    endtask

    // sampled at the falling edge, where everything is settled
    always @(negedge cache) begin
        core_pkg::wb_t exp;
        if (!rstart) begin
            if (down_valid && !down_ready) check(up_ready, 1'b0, "up ready while down stalled");
            if (up_valid && up_ready) model_upstream();
            if (down_valid && down_ready) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("writeback item at time %0t with nothing outstanding", $time);
                end else begin
                    exp = expected_q.pop_front();
                    check(32'(down_op), 32'(exp.op), "writeback op");
                    check(32'(down_rd), 32'(exp.rd), "writeback rd");
                    check(down_data, exp.rd_data, "writeback data");
                end
            end
        end
    end

    task automatic step_cycle();
        @(posedge cache);
        #1;
        down_ready = ((next_rand() >> 16) % 100) < ready_pct;
    endtask

    task automatic send_item(input core_pkg::op_t op, input core_pkg::word_t alu,
                             input core_pkg::word_t rs2, input core_pkg::reg_addr_t rd,
                             input int gap);
        int waited;
        bit done;
        if (!timed_out) begin
            repeat (gap) step_cycle();
            up_valid = 1'b1;
            up_op    = op;
            up_alu   = alu;
            up_rs2   = rs2;
            up_rd    = rd;
            waited   = 0;
            done     = 1'b0;
            while (!done) begin
                @(negedge cache);
                done = up_ready;
                step_cycle();
                waited++;
                if (!done && waited > TIMEOUT) begin
                    $display("timeout: %s item at %h was never accepted", op.name(), alu);
                    timed_out = 1'b1;
                    done      = 1'b1;
                end
            end
            up_valid = 1'b0;
        end
    endtask

    initial begin
        core_pkg::op_t   op;
        core_pkg::word_t addr;
        int              nb;
        int              gap;
        int              waited;
        rstart     = 1'b1;
        up_valid   = 1'b0;
        up_op      = core_pkg::NULL;
        up_alu     = '0;
        up_rs2     = '0;
        up_rd      = '0;
        down_ready = 1'b0;
        repeat (3) @(posedge cache);
        #1 rstart = 1'b0;

        // quiet outputs until something is offered
        repeat (4) begin
            @(negedge cache);
            check(up_ready, 1'b0, "up ready after reset");
            check(down_valid, 1'b0, "down valid after reset");
            step_cycle();
        end

        // RAM starts undefined, fill the window first
        for (int a = 0; a < WINDOW; a += 4) begin
            send_item(core_pkg::STORE_WORD, a, next_rand(), 5'(a >> 2), 0);
        end

        send_item(core_pkg::ALU, 32'h1234_5678, 32'h0, 5'd5, 0);
        send_item(core_pkg::NULL, 32'hcafe_0001, 32'h0, 5'd0, 1);
        send_item(core_pkg::STORE_WORD, 32'h40, 32'h80f1_7f82, 5'd1, 0);
        send_item(core_pkg::LOAD_WORD, 32'h40, 32'h0, 5'd2, 0);
        for (int off = 0; off < 4; off++) begin
            send_item(core_pkg::LOAD_BYTE, 32'h40 + off, 32'h0, 5'd3, 0);
            send_item(core_pkg::LOAD_BYTE_UNSIGNED, 32'h40 + off, 32'h0, 5'd4, 0);
            if (off % 2 == 0) begin
                send_item(core_pkg::LOAD_HALF, 32'h40 + off, 32'h0, 5'd6, 0);
                send_item(core_pkg::LOAD_HALF_UNSIGNED, 32'h40 + off, 32'h0, 5'd7, 0);
            end
        end
        send_item(core_pkg::STORE_HALF, 32'h42, 32'h5555_beef, 5'd8, 0);
        send_item(core_pkg::STORE_BYTE, 32'h41, 32'haaaa_aa11, 5'd9, 0);
        send_item(core_pkg::LOAD_WORD, 32'h40, 32'h0, 5'd10, 0);

        // mixed traffic with stalls on both sides
        ready_pct = 70;
        for (int i = 0; i < 2000 && !timed_out; i++) begin
            op   = core_pkg::op_t'(4'((next_rand() >> 16) % 10));
            nb   = access_bytes(op);
            addr = next_rand();
            if (nb > 0) addr = (addr % WINDOW) & ~(nb - 1);
            gap  = ((next_rand() >> 16) % 4 == 0) ? (next_rand() >> 16) % 3 : 0;
            send_item(op, addr, next_rand(), 5'(next_rand() >> 20), gap);
        end

        ready_pct = 100;
        waited    = 0;
        while (expected_q.size() > 0 && !timed_out) begin
            step_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: %0d writeback items never arrived", expected_q.size());
                timed_out = 1'b1;
            end
        end

        $display("errors: %0d, timeouts: %0d", errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
design/core_pkg.sv
design/stream_if.sv
design/wb_if.sv
design/mem_align.sv
design/mem_control.sv
design/data_ram.sv
design/mem_stage.sv
testbench/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - design/core_pkg.sv
  - design/stream_if.sv
  - design/wb_if.sv
  - design/mem_align.sv
  - design/mem_control.sv
  - design/data_ram.sv
  - design/mem_stage.sv
  - target: test
    files:
      - testbench/tb_mem_stage.sv
